// ==== logic/vga_pkg.sv ====
// shared types for the VGA scan doubler
// pixel and buffer address widths, APB register map, datapath configuration
`default_nettype none

package vga_pkg;

	// 6-bit colour, as sent to the DAC
	typedef logic [5:0] pixel_t;

	// {bank[1:0], page, offset[7:0]}
	typedef logic [10:0] buf_addr_t;

	typedef logic [7:0] apb_addr_t;  // byte address
	typedef logic [31:0] apb_data_t;

	// source line counter, wraps
	typedef logic [15:0] line_cnt_t;

	// register map
	localparam apb_addr_t REG_CTRL   = 8'h00;  // bit 0 enable
	localparam apb_addr_t REG_BORDER = 8'h04;  // bits 5:0 border colour
	localparam apb_addr_t REG_LINES  = 8'h08;  // read only

	// configuration handed from the register block to the datapath
	typedef struct packed {
		logic   enable;
		pixel_t border;
	} video_cfg_t;

endpackage

`default_nettype wire

// ==== logic/line_buffer.sv ====
// line buffer of the scan doubler
// three banks of 512 pixels, synchronous write, registered read
`timescale 1ns/1ps
`default_nettype none

module line_buffer (
	input  wire                 clk,
	input  vga_pkg::buf_addr_t  wraddr,
	input  vga_pkg::pixel_t     wrdata,
	input  wire                 wr_stb,
	input  vga_pkg::buf_addr_t  rdaddr,
	output vga_pkg::pixel_t     rddata
);

	// bank 3 is never addressed, so 1536 words suffice
	vga_pkg::pixel_t mem [0:1535];

	always_ff @(posedge clk)
	begin
		if (wr_stb)
		begin
			mem[wraddr] <= wrdata;
		end
		rddata <= mem[rdaddr];  // one clock read latency
	end

endmodule

`default_nettype wire

// ==== logic/scan_doubler.sv ====
// scan doubler: writes a source line at half rate into one page
// and reads the other page twice at full rate
`timescale 1ns/1ps
`default_nettype none

module scan_doubler #(
	parameter int ACTIVE_PIXELS = 720
) (
	input  wire              clk,
	input  wire              reset,
	input  wire              src_line_start,
	input  wire              scanin_start,
	input  vga_pkg::pixel_t  pix_in,
	input  wire              line_start,
	output vga_pkg::pixel_t  pix_out,
	output logic             active
);

	// pointers park here when a line is done
	localparam logic [9:0] PIX_END = 10'(ACTIVE_PIXELS);

	logic [9:0] wr_ptr;
	logic       wr_phase;  // high on the second clock of each source pixel
	logic       wr_stb;
	logic [9:0] rd_ptr;
	logic       rd_en;
	logic       rd_en_d;   // rd_en lined up with rddata
	logic       page;      // page being written
	logic       line_seen;
	logic       rd_ok;     // read page holds a full source line

	vga_pkg::buf_addr_t wraddr;
	vga_pkg::buf_addr_t rdaddr;
	vga_pkg::pixel_t    rddata;

	// page swap at every source line boundary
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			page      <= 1'b0;
			line_seen <= 1'b0;
			rd_ok     <= 1'b0;
		end
		else if (src_line_start)
		begin
			page      <= ~page;
			line_seen <= 1'b1;
			rd_ok     <= line_seen;  // nothing written before the first swap
		end
	end

	// write pointer advances every second clock
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr   <= PIX_END;
			wr_phase <= 1'b0;
		end
		else if (scanin_start)
		begin
			wr_ptr   <= '0;
			wr_phase <= 1'b0;
		end
		else if (wr_ptr != PIX_END)
		begin
			wr_phase <= ~wr_phase;
			if (wr_phase)
			begin
				wr_ptr <= wr_ptr + 10'd1;
			end
		end
	end

	assign wr_stb = wr_phase && (wr_ptr != PIX_END);

	// read pointer restarts on each VGA line
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_ptr <= PIX_END;
		end
		else if (line_start)
		begin
			rd_ptr <= '0;
		end
		else if (rd_en)
		begin
			rd_ptr <= rd_ptr + 10'd1;
		end
	end

	assign rd_en = (rd_ptr != PIX_END);

	assign wraddr = {wr_ptr[9:8], page, wr_ptr[7:0]};
	assign rdaddr = {rd_ptr[9:8], ~page, rd_ptr[7:0]};

	line_buffer u_line_buffer (
		.clk    (clk),
		.wraddr (wraddr),
		.wrdata (pix_in),
		.wr_stb (wr_stb),
		.rdaddr (rdaddr),
		.rddata (rddata)
	);

	// output register, blanked outside the window
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_en_d <= 1'b0;
			active  <= 1'b0;
		end
		else
		begin
			rd_en_d <= rd_en;
			active  <= rd_en_d;
		end
		pix_out <= (rd_en_d && rd_ok) ? rddata : '0;
	end

endmodule

`default_nettype wire

// ==== logic/line_timing.sv ====
// horizontal timing: VGA line start, source line start every second
// line, and the hsync pulse
`timescale 1ns/1ps
`default_nettype none

module line_timing #(
	parameter int LINE_CLOCKS  = 858,
	parameter int HSYNC_CLOCKS = 62
) (
	input  wire   clk,
	input  wire   reset,
	output logic  line_start,
	output logic  src_line_start,
	output logic  hsync
);

	localparam int CW = $clog2(LINE_CLOCKS);

	localparam logic [CW-1:0] CNT_LAST  = CW'(LINE_CLOCKS - 1);
	localparam logic [CW-1:0] SYNC_LEN  = CW'(HSYNC_CLOCKS);

	logic [CW-1:0] cnt;     // clock within the VGA line
	logic          parity;  // low on lines that begin a source line
	logic          wrap;

	assign wrap = (cnt == CNT_LAST);

	// clock counter, starts at 0 right out of reset
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cnt    <= '0;
			parity <= 1'b0;
		end
		else
		begin
			cnt <= wrap ? '0 : cnt + 1'b1;
			if (cnt == '0)
			begin
				parity <= ~parity;
			end
		end
	end

	// outputs registered from the count
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			line_start     <= 1'b0;
			src_line_start <= 1'b0;
			hsync          <= 1'b0;
		end
		else
		begin
			line_start     <= (cnt == '0);
			src_line_start <= (cnt == '0) && !parity;
			hsync          <= (cnt < SYNC_LEN);  // counts 0 .. HSYNC_CLOCKS-1
		end
	end

endmodule

`default_nettype wire

// ==== logic/video_regs.sv ====
// APB register block for the scan doubler
// control, border colour and a source line counter
`timescale 1ns/1ps
`default_nettype none

module video_regs (
	input  wire                   clk,
	input  wire                   reset,
	input  vga_pkg::apb_addr_t    paddr,
	input  wire                   psel,
	input  wire                   penable,
	input  wire                   pwrite,
	input  vga_pkg::apb_data_t    pwdata,
	output vga_pkg::apb_data_t    prdata,
	output logic                  pready,
	output logic                  pslverr,
	input  wire                   line_tick,
	output vga_pkg::video_cfg_t   cfg
);

	logic                enable;
	vga_pkg::pixel_t     border;
	vga_pkg::line_cnt_t  lines;
	logic                access;
	logic                mapped;

	assign access = psel && penable;

	always_comb
	begin
		case (paddr)
			vga_pkg::REG_CTRL,
			vga_pkg::REG_BORDER,
			vga_pkg::REG_LINES: mapped = 1'b1;
			default:            mapped = 1'b0;
		endcase
	end

	// writes land in the access phase
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			enable <= 1'b0;
			border <= '0;
		end
		else if (access && pwrite)
		begin
			if (paddr == vga_pkg::REG_CTRL)
			begin
				enable <= pwdata[0];
			end
			if (paddr == vga_pkg::REG_BORDER)
			begin
				border <= pwdata[5:0];
			end
		end
	end

	// one count per scanin_start, wraps at 16 bits
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			lines <= '0;
		end
		else if (line_tick)
		begin
			lines <= lines + 16'd1;
		end
	end

	always_comb
	begin
		prdata = '0;
		case (paddr)
			vga_pkg::REG_CTRL:   prdata[0]    = enable;
			vga_pkg::REG_BORDER: prdata[5:0]  = border;
			vga_pkg::REG_LINES:  prdata[15:0] = lines;
			default:             prdata       = '0;
		endcase
	end

	assign pready  = 1'b1;  // no wait states
	assign pslverr = access && !mapped;

	assign cfg.enable = enable;
	assign cfg.border = border;

endmodule

`default_nettype wire

// ==== logic/vga_top.sv ====
// VGA scan doubler top: registers, line timing and doubler,
// with the border multiplexer on the pixel output
`timescale 1ns/1ps
`default_nettype none

module vga_top #(
	parameter int ACTIVE_PIXELS = 720,
	parameter int LINE_CLOCKS   = 858,
	parameter int HSYNC_CLOCKS  = 62
) (
	input  wire                 clk,
	input  wire                 reset,
	input  vga_pkg::apb_addr_t  paddr,
	input  wire                 psel,
	input  wire                 penable,
	input  wire                 pwrite,
	input  vga_pkg::apb_data_t  pwdata,
	output vga_pkg::apb_data_t  prdata,
	output logic                pready,
	output logic                pslverr,
	output logic                src_line_start,
	input  wire                 scanin_start,
	input  vga_pkg::pixel_t     pix_in,
	output logic                hsync,
	output vga_pkg::pixel_t     pix_out
);

	vga_pkg::video_cfg_t cfg;
	vga_pkg::pixel_t     dbl_pix;
	logic                dbl_active;
	logic                line_start;

	video_regs u_regs (
		.clk       (clk),
		.reset     (reset),
		.paddr     (paddr),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.line_tick (scanin_start),  // one per source line
		.cfg       (cfg)
	);

	line_timing #(
		.LINE_CLOCKS  (LINE_CLOCKS),
		.HSYNC_CLOCKS (HSYNC_CLOCKS)
	) u_timing (
		.clk            (clk),
		.reset          (reset),
		.line_start     (line_start),
		.src_line_start (src_line_start),
		.hsync          (hsync)
	);

	scan_doubler #(
		.ACTIVE_PIXELS (ACTIVE_PIXELS)
	) u_doubler (
		.clk            (clk),
		.reset          (reset),
		.src_line_start (src_line_start),
		.scanin_start   (scanin_start),
		.pix_in         (pix_in),
		.line_start     (line_start),
		.pix_out        (dbl_pix),
		.active         (dbl_active)
	);

	// border outside the window or when the doubler is bypassed
	assign pix_out = (cfg.enable && dbl_active) ? dbl_pix : cfg.border;

endmodule

`default_nettype wire

// ==== testbench/vga_assertions.sv ====
// bound checks on the scan doubler top
// timing pulses, APB protocol and the border blanking rule
`timescale 1ns/1ps
`default_nettype none

module vga_assertions #(
	parameter int HSYNC_CLOCKS = 62
) (
	input wire                  clk,
	input wire                  reset,
	input wire                  hsync,
	input wire                  src_line_start,
	input wire                  psel,
	input wire                  penable,
	input vga_pkg::video_cfg_t  cfg,
	input vga_pkg::pixel_t      pix_out
);

	int fail_count = 0;  // read by the testbench at the end

	// a source line begins only with a VGA line
	sls_on_line_start: assert property (@(posedge clk) disable iff (reset)
		src_line_start |-> $rose(hsync))
	else
	begin
		fail_count++;
		$error("src_line_start without hsync rising");
	end

	hsync_width: assert property (@(posedge clk) disable iff (reset)
		$rose(hsync) |-> ##HSYNC_CLOCKS !hsync)
	else
	begin
		fail_count++;
		$error("hsync pulse width wrong");
	end

	apb_enable_in_select: assert property (@(posedge clk) disable iff (reset)
		penable |-> psel)
	else
	begin
		fail_count++;
		$error("penable without psel");
	end

	// line start falls in the blanking interval
	border_at_line_start: assert property (@(posedge clk) disable iff (reset)
		$rose(hsync) |-> pix_out == cfg.border)
	else
	begin
		fail_count++;
		$error("pix_out not border at line start");
	end

endmodule

bind vga_top vga_assertions #(
	.HSYNC_CLOCKS (HSYNC_CLOCKS)
) u_assertions (
	.clk            (clk),
	.reset          (reset),
	.hsync          (hsync),
	.src_line_start (src_line_start),
	.psel           (psel),
	.penable        (penable),
	.cfg            (cfg),
	.pix_out        (pix_out)
);

`default_nettype wire

// ==== testbench/vga_tb.sv ====
// testbench for the VGA scan doubler
// random source lines and APB traffic, checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module vga_tb;

	localparam int ACTIVE_PIXELS = 40;
	localparam int LINE_CLOCKS   = 64;
	localparam int HSYNC_CLOCKS  = 6;
	localparam int MAX_SRC_LINES = 40;
	localparam int WATCHDOG_NS   = MAX_SRC_LINES * 2 * LINE_CLOCKS * 10 + 2000;
	localparam logic [31:0] RAND_SEED = 32'ha3e7;

	logic               clk;
	logic               reset;
	vga_pkg::apb_addr_t paddr;
	logic               psel;
	logic               penable;
	logic               pwrite;
	vga_pkg::apb_data_t pwdata;
	vga_pkg::apb_data_t prdata;
	logic               pready;
	logic               pslverr;
	logic               src_line_start;
	logic               scanin_start;
	vga_pkg::pixel_t    pix_in;
	logic               hsync;
	vga_pkg::pixel_t    pix_out;

	// reference model
	logic               model_enable;
	vga_pkg::pixel_t    model_border;
	vga_pkg::line_cnt_t model_lines;  // wraps like the register
	vga_pkg::pixel_t    line_mem [0:1][0:ACTIVE_PIXELS-1];  // indexed by source line parity
	int                 src_line;
	int                 errors;
	int                 pix_checks;

	// monitor state
	int                 vga_line;
	int                 pos;       // clocks since the line start clock
	int                 sync_len;
	logic               hsync_q;

	vga_top #(
		.ACTIVE_PIXELS (ACTIVE_PIXELS),
		.LINE_CLOCKS   (LINE_CLOCKS),
		.HSYNC_CLOCKS  (HSYNC_CLOCKS)
	) u_vga_top (
		.clk            (clk),
		.reset          (reset),
		.paddr          (paddr),
		.psel           (psel),
		.penable        (penable),
		.pwrite         (pwrite),
		.pwdata         (pwdata),
		.prdata         (prdata),
		.pready         (pready),
		.pslverr        (pslverr),
		.src_line_start (src_line_start),
		.scanin_start   (scanin_start),
		.pix_in         (pix_in),
		.hsync          (hsync),
		.pix_out        (pix_out)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic is_mapped(input vga_pkg::apb_addr_t addr);
		return addr == vga_pkg::REG_CTRL || addr == vga_pkg::REG_BORDER ||
			addr == vga_pkg::REG_LINES;
	endfunction

	function automatic vga_pkg::apb_data_t expected_read(input vga_pkg::apb_addr_t addr);
		vga_pkg::apb_data_t value;
		value = '0;
		if (addr == vga_pkg::REG_CTRL)
			value[0] = model_enable;
		else if (addr == vga_pkg::REG_BORDER)
			value[5:0] = model_border;
		else if (addr == vga_pkg::REG_LINES)
			value[15:0] = model_lines;
		return value;
	endfunction

	// one APB transfer, setup then access, sampled on the completing edge
	task automatic apb_access(input vga_pkg::apb_addr_t addr, input logic write,
		input vga_pkg::apb_data_t wdata, output vga_pkg::apb_data_t rdata, output logic err);
		@(negedge clk);
		paddr   = addr;
		pwrite  = write;
		pwdata  = wdata;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		@(posedge clk);
		rdata = prdata;
		err   = pslverr;
		if (pready !== 1'b1)
		begin
			errors++;
			$display("MISMATCH at %0t: pready low in access phase", $time);
		end
		if (write && addr == vga_pkg::REG_CTRL)
			model_enable <= wdata[0];
		if (write && addr == vga_pkg::REG_BORDER)
			model_border <= wdata[5:0];
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic reg_write(input vga_pkg::apb_addr_t addr, input vga_pkg::apb_data_t data);
		vga_pkg::apb_data_t rdata;
		logic err;
		apb_access(addr, 1'b1, data, rdata, err);
		if (err !== !is_mapped(addr))
		begin
			errors++;
			$display("MISMATCH at %0t: write to %h, pslverr %b", $time, addr, err);
		end
	endtask

	task automatic reg_read_check(input vga_pkg::apb_addr_t addr);
		vga_pkg::apb_data_t rdata;
		vga_pkg::apb_data_t expected;
		logic err;
		expected = expected_read(addr);  // taken before the access edge
		apb_access(addr, 1'b0, '0, rdata, err);
		if (err !== !is_mapped(addr))
		begin
			errors++;
			$display("MISMATCH at %0t: read of %h, pslverr %b", $time, addr, err);
		end
		if (is_mapped(addr) && rdata !== expected)
		begin
			errors++;
			$display("MISMATCH at %0t: read of %h gave %h, expected %h",
				$time, addr, rdata, expected);
		end
	endtask

	task automatic wait_src_line;
		@(posedge clk);
		while (!src_line_start)
			@(posedge clk);
	endtask

	// new border somewhere inside the current source line
	task automatic change_border;
		int delay;
		delay = $urandom % 91;
		repeat (delay) @(negedge clk);
		reg_write(vga_pkg::REG_BORDER, $urandom);
	endtask

	// source side, pixel i held for clocks 2i+1 and 2i+2 after scanin_start
	initial
	begin : source
		int slot;
		forever
		begin
			@(posedge clk);
			if (!reset && src_line_start)
			begin
				slot = src_line & 1;
				for (int i = 0; i < ACTIVE_PIXELS; i++)
					line_mem[slot][i] = vga_pkg::pixel_t'($urandom);
				src_line++;
				@(negedge clk);
				scanin_start = 1'b1;
				pix_in       = line_mem[slot][0];
				for (int i = 0; i < ACTIVE_PIXELS; i++)
				begin
					@(negedge clk);
					scanin_start = 1'b0;
					pix_in       = line_mem[slot][i];
					@(negedge clk);
				end
				@(negedge clk);
				pix_in = vga_pkg::pixel_t'($urandom);  // beyond the line, never stored
			end
		end
	end

	always @(posedge clk)
	begin
		if (reset)
			model_lines <= '0;
		else if (scanin_start)
			model_lines <= model_lines + 16'd1;
	end

	// line timing and pixel checks, one sample per clock
	always @(posedge clk)
	begin : monitor
		logic            rise;
		logic            exp_sls;
		vga_pkg::pixel_t expected;
		int              s;
		if (reset)
		begin
			vga_line = -1;
			pos      = 0;
			sync_len = 0;
			hsync_q  = 1'b0;
		end
		else
		begin
			rise = hsync && !hsync_q;
			if (rise)
			begin
				if (vga_line >= 0 && pos != LINE_CLOCKS - 1)
				begin
					errors++;
					$display("MISMATCH at %0t: hsync period %0d", $time, pos + 1);
				end
				vga_line++;
				pos = 0;
			end
			else if (vga_line >= 0)
				pos++;
			exp_sls = rise && (vga_line % 2 == 0);
			if (src_line_start !== exp_sls)
			begin
				errors++;
				$display("MISMATCH at %0t: src_line_start %b, expected %b",
					$time, src_line_start, exp_sls);
			end
			if (hsync)
				sync_len++;
			else if (hsync_q)
			begin
				if (sync_len != HSYNC_CLOCKS)
				begin
					errors++;
					$display("MISMATCH at %0t: hsync width %0d", $time, sync_len);
				end
				sync_len = 0;
			end
			// first source line after reset holds no stored data
			if (vga_line >= 2)
			begin
				s = vga_line / 2;
				if (model_enable && pos >= 3 && pos < 3 + ACTIVE_PIXELS)
				begin
					expected = line_mem[(s - 1) & 1][pos - 3];
					pix_checks++;
				end
				else
					expected = model_border;
				if (pix_out !== expected)
				begin
					errors++;
					$display("MISMATCH at %0t: line %0d clock %0d pix_out %h, expected %h",
						$time, vga_line, pos, pix_out, expected);
				end
			end
			hsync_q = hsync;
		end
	end

	initial
	begin : watchdog
		#(WATCHDOG_NS);
		$display("timeout: run still going after %0d ns, %0d errors so far",
			WATCHDOG_NS, errors);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin : main
		vga_pkg::apb_addr_t bad_addr;
		int                 total;
		void'($urandom(RAND_SEED));
		reset        = 1'b1;
		paddr        = '0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		pwdata       = '0;
		scanin_start = 1'b0;
		pix_in       = '0;
		model_enable = 1'b0;
		model_border = '0;
		src_line     = 0;
		errors       = 0;
		pix_checks   = 0;
		repeat (5) @(negedge clk);
		reset = 1'b0;

		// reset values, read back, unmapped addresses
		reg_read_check(vga_pkg::REG_LINES);  // before the first scanin_start counts
		reg_read_check(vga_pkg::REG_CTRL);
		reg_read_check(vga_pkg::REG_BORDER);
		repeat (4)
		begin
			reg_write(vga_pkg::REG_CTRL, $urandom);
			reg_read_check(vga_pkg::REG_CTRL);
			reg_write(vga_pkg::REG_BORDER, $urandom);
			reg_read_check(vga_pkg::REG_BORDER);
		end
		reg_write(vga_pkg::REG_LINES, $urandom);  // read only
		reg_read_check(vga_pkg::REG_LINES);
		do
			bad_addr = vga_pkg::apb_addr_t'($urandom);
		while (is_mapped(bad_addr));
		reg_write(bad_addr, $urandom);
		reg_read_check(bad_addr);

		// doubled lines
		reg_write(vga_pkg::REG_CTRL, 32'h1);
		repeat (8)
		begin
			wait_src_line();
			change_border();
		end

		// bypass, border only
		reg_write(vga_pkg::REG_CTRL, $urandom & 32'hffff_fffe);
		repeat (5)
		begin
			wait_src_line();
			change_border();
		end

		reg_write(vga_pkg::REG_CTRL, 32'h1);
		repeat (6)
		begin
			wait_src_line();
			change_border();
		end
		reg_read_check(vga_pkg::REG_LINES);
		reg_read_check(vga_pkg::REG_CTRL);

		if (pix_checks == 0)
		begin
			errors++;
			$display("no active pixel was compared during the run");
		end
		total = errors + u_vga_top.u_assertions.fail_count;
		$display("run complete: %0d check errors, %0d assertion failures, %0d pixels compared",
			errors, u_vga_top.u_assertions.fail_count, pix_checks);
		if (total == 0)
		begin
			$display("SIMULATION PASSED");
		end
		else
		begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
logic/vga_pkg.sv
logic/line_buffer.sv
logic/scan_doubler.sv
logic/line_timing.sv
logic/video_regs.sv
logic/vga_top.sv
testbench/vga_assertions.sv
testbench/vga_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the scan doubler testbench with Verilator
# the run passes only when the testbench prints its pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module vga_tb -f build.f -o vga_sim || { echo "build failed"; exit 1; }

out=$(./obj_dir/vga_sim +verilator+error+limit+1000)
echo "$out"

echo "$out" | grep -qx "SIMULATION PASSED" && echo "run passed" || { echo "run failed"; exit 1; }
